// File: sources.f
+incdir+src
src/mem_pkg.sv
src/host_pkg.sv
src/mem_req_if.sv
src/download_loader.sv
src/cycle_arbiter.sv
src/mem_store.sv
src/atom_mem_top.sv
verif/mem_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile the Atom memory subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

echo "Compiling with Verilator"
verilator --binary --timing \
    -f sources.f \
    --top-module tb_top \
    --Mdir obj_dir \
    -o tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Compile failed with status $status, see $BUILD_LOG"
    exit 1
fi

echo "Running simulation"
./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    echo "Result: failure reported in $SIM_LOG"
    exit 1
fi

echo "Result: no failure reported"
exit 0

// File: verif/tb_top.sv
/*
 * Testbench top for the Atom memory subsystem
 *   clock, reset, phi2 generator and watchdog
 *   seeded random download and CPU bus stimulus per test
 */
`timescale 1ns/10ps
`include "atom_params.svh"

module tb_top;

    localparam int PERIOD     = 32;
    localparam int DL_BYTES   = 256;
    localparam int LOCK_WRITES = 6;
    localparam int MIX_PERIODS = 200;
    localparam int HOLD_WAIT  = 4 * `ATOM_HOLD_CYCLES;

    // Cycle budget of each test, summed for the watchdog
    localparam int BUDGET = 16 + 40
                          + 2 * (DL_BYTES * 6 + 300 + (DL_BYTES + 2) * PERIOD)
                          + (16 * 6 + 300 + 2 * PERIOD)
                          + (300 + 2 * (LOCK_WRITES + 3) * PERIOD)
                          + (MIX_PERIODS + 2) * PERIOD;

    logic                  clk_sys;
    logic                  reset;
    logic                  ioctl_download;
    host_pkg::file_index_t ioctl_index;
    logic                  ioctl_wr;
    host_pkg::host_addr_t  ioctl_addr;
    mem_pkg::byte_t        ioctl_dout;
    logic                  cpu_phi2;
    logic                  cpu_we;
    mem_pkg::cpu_addr_t    cpu_addr;
    mem_pkg::byte_t        cpu_din;
    mem_pkg::byte_t        cpu_dout;
    logic                  core_reset;

    logic [4:0]            phase;
    integer                seed;
    mem_pkg::cpu_addr_t    rom_addrs[$];
    mem_pkg::cpu_addr_t    known_addrs[$];

    atom_mem_top atom_mem_top_inst (.*);

    mem_checker checker_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // phi2 high for half of each 32-cycle period
    always @(posedge clk_sys) begin
        cpu_phi2 <= (phase < 5'd16);
        phase    <= phase + 5'd1;
    end

    initial begin
        repeat (BUDGET * 3 / 2) @(posedge clk_sys);
        $display("Timeout: tests did not finish within %0d cycles", BUDGET * 3 / 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // New CPU bus values start with the phi2 rising edge
    task automatic run_period(input logic we, input mem_pkg::cpu_addr_t addr,
                              input mem_pkg::byte_t din);
        @(posedge clk_sys);
        while (phase != 5'd0) begin
            @(posedge clk_sys);
        end
        cpu_we   <= we;
        cpu_addr <= addr;
        cpu_din  <= din;
    endtask

    task automatic wait_core_reset(input logic level, input string what);
        int n;
        n = 0;
        while (core_reset !== level && n < HOLD_WAIT) begin
            @(posedge clk_sys);
            n++;
        end
        if (core_reset !== level) begin
            checker_inst.note_failure(what);
        end
    endtask

    task automatic run_download(input host_pkg::file_index_t idx, input int count,
                                input bit reuse);
        logic [31:0] r;
        int          n;
        n = reuse ? rom_addrs.size() : count;
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        ioctl_index    <= idx;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            @(posedge clk_sys);
            ioctl_wr   <= 1'b1;
            ioctl_dout <= r[7:0];
            if (reuse) begin
                ioctl_addr <= {r[14:8], rom_addrs[i]};
            end else begin
                r = $random(seed);
                ioctl_addr <= r[24:0];
                rom_addrs.push_back(r[17:0]);
                known_addrs.push_back(r[17:0]);
            end
            @(posedge clk_sys);
            ioctl_wr <= 1'b0;
            repeat (r[31:30]) @(posedge clk_sys);
        end
        @(posedge clk_sys);
        ioctl_download <= 1'b0;
        // Park the bus on a known address while the hold span runs
        run_period(1'b0, rom_addrs[0], 8'h00);
        wait_core_reset(1'b0, "core_reset did not fall after the download ended");
    endtask

    task automatic read_rom_addrs();
        for (int i = 0; i < rom_addrs.size(); i++) begin
            run_period(1'b0, rom_addrs[i], 8'h00);
        end
        run_period(1'b0, rom_addrs[0], 8'h00);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        checker_inst.finish_test(name);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [31:0]        r;
        int unsigned        pick;
        mem_pkg::cpu_addr_t a;

        seed           = 32'h03f29500;
        phase          = '0;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_index    = '0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        cpu_phi2       = 1'b0;
        cpu_we         = 1'b0;
        cpu_addr       = '0;
        cpu_din        = '0;

        repeat (16) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (4) @(posedge clk_sys);
        end_test("reset state");

        run_download(8'h00, DL_BYTES, 1'b0);
        read_rom_addrs();
        end_test("ROM download and readback");

        run_download(8'h01, DL_BYTES, 1'b1);
        read_rom_addrs();
        end_test("odd index download ignored");

        run_download(8'h02, 16, 1'b0);
        end_test("core_reset hold span");

        // Download with no writes keeps the core in reset
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        ioctl_index    <= 8'h03;
        wait_core_reset(1'b1, "core_reset did not rise during the download");
        for (int i = 0; i < LOCK_WRITES; i++) begin
            r = $random(seed);
            run_period(1'b1, rom_addrs[i], r[7:0]);
        end
        run_period(1'b0, rom_addrs[0], 8'h00);
        @(posedge clk_sys);
        ioctl_download <= 1'b0;
        wait_core_reset(1'b0, "core_reset did not fall after the download ended");
        for (int i = 0; i < LOCK_WRITES; i++) begin
            run_period(1'b0, rom_addrs[i], 8'h00);
        end
        run_period(1'b0, rom_addrs[0], 8'h00);
        end_test("CPU writes blocked in reset");

        for (int i = 0; i < MIX_PERIODS; i++) begin
            r = $random(seed);
            if (r[0]) begin
                a = r[25:8];
                known_addrs.push_back(a);
                run_period(1'b1, a, r[31:24]);
            end else begin
                pick = $unsigned($random(seed)) % known_addrs.size();
                // Upper bits above the store depth are random, so reads alias
                a = {r[6:1], known_addrs[pick][`ATOM_STORE_ADDR_BITS-1:0]};
                run_period(1'b0, a, 8'h00);
            end
        end
        run_period(1'b0, rom_addrs[0], 8'h00);
        end_test("random CPU reads and writes");

        $display("Tests: %0d run, %0d failed, %0d errors", checker_inst.tests_run,
                 checker_inst.tests_failed, checker_inst.total_errors);
        if (checker_inst.tests_failed == 0 && checker_inst.total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/mem_checker.sv
/*
 * Testbench checker for the Atom memory subsystem
 *   byte model of the store, updated from host and CPU writes
 *   read comparison per phi2 period, reset and hold timing checks
 *   per-test result lines and error counts
 */
`timescale 1ns/10ps
`include "atom_params.svh"

module mem_checker (
    input logic                  clk_sys,
    input logic                  reset,
    input logic                  ioctl_download,
    input host_pkg::file_index_t ioctl_index,
    input logic                  ioctl_wr,
    input host_pkg::host_addr_t  ioctl_addr,
    input mem_pkg::byte_t        ioctl_dout,
    input logic                  cpu_phi2,
    input logic                  cpu_we,
    input mem_pkg::cpu_addr_t    cpu_addr,
    input mem_pkg::byte_t        cpu_din,
    input mem_pkg::byte_t        cpu_dout,
    input logic                  core_reset
);

    localparam int DEPTH = 1 << `ATOM_STORE_ADDR_BITS;

    mem_pkg::byte_t     model [0:DEPTH-1];
    bit                 known [0:DEPTH-1];

    int                 tests_run;
    int                 tests_failed;
    int                 total_errors;
    int                 test_errors;
    int                 test_compares;

    // Period tracking, own copy of phi2
    logic               phi2_q;
    logic               per_open;
    logic               per_we;
    logic               per_clean;
    mem_pkg::cpu_addr_t per_addr;
    mem_pkg::byte_t     per_din;

    logic               reset_q;
    logic               dl_q;
    logic               dl_q2;
    logic               hold_armed;
    int                 hold_count;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            known[i] = 1'b0;
            model[i] = '0;
        end
        tests_run     = 0;
        tests_failed  = 0;
        total_errors  = 0;
        test_errors   = 0;
        test_compares = 0;
        phi2_q        = 1'b0;
        per_open      = 1'b0;
        per_we        = 1'b0;
        per_clean     = 1'b0;
        per_addr      = '0;
        per_din       = '0;
        reset_q       = 1'b1;
        dl_q          = 1'b0;
        dl_q2         = 1'b0;
        hold_armed    = 1'b0;
        hold_count    = 0;
    end

    task automatic count_error();
        test_errors++;
        total_errors++;
    endtask

    // Used by the stimulus side for failures that are not value compares
    task automatic note_failure(input string msg);
        $display("ERROR: %s", msg);
        count_error();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok, %0d reads compared", tests_run, name, test_compares);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
        end
        test_errors   = 0;
        test_compares = 0;
    endtask

    //////////////////////////////
    // Period close
    //////////////////////////////

    task automatic close_period();
        mem_pkg::store_addr_t a;
        a = per_addr[`ATOM_STORE_ADDR_BITS-1:0];
        if (per_we) begin
            model[a] = per_din;
            known[a] = 1'b1;
        end else if (known[a]) begin
            // Store contents never written are unknown, so only known bytes compare
            test_compares++;
            if (cpu_dout !== model[a]) begin
                $display("MISMATCH cpu_dout addr %h: expected %h, got %h",
                         per_addr, model[a], cpu_dout);
                count_error();
            end
        end
    endtask

    always @(posedge clk_sys) begin
        // Values right after reset
        if (reset_q && !reset) begin
            if (core_reset !== 1'b1) begin
                $display("MISMATCH core_reset after reset: expected 1, got %h", core_reset);
                count_error();
            end
            if (cpu_dout !== 8'h00) begin
                $display("MISMATCH cpu_dout after reset: expected 00, got %h", cpu_dout);
                count_error();
            end
        end

        // Host download writes to the ROM target
        if (!reset && ioctl_download && ioctl_wr && !ioctl_index[0]) begin
            model[ioctl_addr[`ATOM_STORE_ADDR_BITS-1:0]] = ioctl_dout;
            known[ioctl_addr[`ATOM_STORE_ADDR_BITS-1:0]] = 1'b1;
        end

        // Core held in reset while a download runs
        if (!reset && dl_q && dl_q2 && core_reset !== 1'b1) begin
            $display("MISMATCH core_reset during download: expected 1, got %h", core_reset);
            count_error();
        end

        // Hold span after the download ends
        if (dl_q && !ioctl_download) begin
            // First cycle after the download fell
            hold_armed = 1'b1;
            hold_count = 1;
        end else if (ioctl_download) begin
            hold_armed = 1'b0;
        end else if (hold_armed) begin
            if (core_reset) begin
                hold_count++;
            end else begin
                hold_armed = 1'b0;
                if (hold_count != `ATOM_HOLD_CYCLES + 1) begin
                    $display("MISMATCH core_reset hold cycles: expected %h, got %h",
                             `ATOM_HOLD_CYCLES + 1, hold_count);
                    count_error();
                end
            end
        end

        // A period only counts if the core was out of reset all through it
        if (cpu_phi2 && !phi2_q) begin
            if (per_open && per_clean && !core_reset && !reset) begin
                close_period();
            end
            per_open  = 1'b1;
            per_we    = cpu_we;
            per_addr  = cpu_addr;
            per_din   = cpu_din;
            per_clean = !core_reset && !reset;
        end else begin
            per_clean = per_clean && !core_reset && !reset;
        end

        phi2_q  = cpu_phi2;
        reset_q = reset;
        dl_q2   = dl_q;
        dl_q    = ioctl_download;
    end

endmodule

// File: src/atom_mem_top.sv
/*
 * Atom memory subsystem top
 *   download loader, slot arbiter and block RAM store
 *   host download and CPU bus on plain ports
 */
`timescale 1ns/10ps

module atom_mem_top (
    input  logic                  clk_sys,
    input  logic                  reset,

    // Host download stream
    input  logic                  ioctl_download,
    input  host_pkg::file_index_t ioctl_index,
    input  logic                  ioctl_wr,
    input  host_pkg::host_addr_t  ioctl_addr,
    input  mem_pkg::byte_t        ioctl_dout,

    // 6502 external bus
    input  logic                  cpu_phi2,
    input  logic                  cpu_we,
    input  mem_pkg::cpu_addr_t    cpu_addr,
    input  mem_pkg::byte_t        cpu_din,
    output mem_pkg::byte_t        cpu_dout,
    output logic                  core_reset
);

    dl_write_if dl_bus ();
    mem_req_if  mem_bus ();

    //////////////////////////////
    // Loader
    //////////////////////////////

    download_loader download_loader_inst (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .dl             (dl_bus.source)
    );

    //////////////////////////////
    // Arbiter and store
    //////////////////////////////

    cycle_arbiter cycle_arbiter_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .cpu_phi2   (cpu_phi2),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_din    (cpu_din),
        .cpu_dout   (cpu_dout),
        .core_reset (core_reset),
        .dl         (dl_bus.sink),
        .mem        (mem_bus.master)
    );

    mem_store mem_store_inst (
        .clk_sys (clk_sys),
        .reset   (reset),
        .mem     (mem_bus.slave)
    );

endmodule

// File: src/mem_store.sv
/*
 * Block RAM byte store
 *   4 KB array, upper address bits alias
 *   fixed-latency read pipeline with ready pulse
 */
`timescale 1ns/10ps
`include "atom_params.svh"

module mem_store (
    input  logic     clk_sys,
    input  logic     reset,
    mem_req_if.slave mem
);

    localparam int DEPTH = 1 << `ATOM_STORE_ADDR_BITS;
    localparam int LAT   = `ATOM_STORE_LATENCY;

    mem_pkg::byte_t      store_mem [0:DEPTH-1];
    mem_pkg::store_addr_t idx;
    mem_pkg::byte_t      data_pipe [0:LAT-1];
    logic [LAT-1:0]      ready_pipe;

    assign idx = mem.addr[`ATOM_STORE_ADDR_BITS-1:0];

    // Array write and first read stage
    always_ff @(posedge clk_sys) begin
        if (mem.we) begin
            store_mem[idx] <= mem.wdata;
        end
        if (mem.rd) begin
            data_pipe[0] <= store_mem[idx];
        end
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // Tracks reads in flight, one bit per stage
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ready_pipe <= '0;
        end else begin
            ready_pipe <= {ready_pipe[LAT-2:0], mem.rd};
        end
    end

    assign mem.ready = ready_pipe[LAT-1];
    assign mem.rdata = data_pipe[LAT-1];

endmodule

// File: src/cycle_arbiter.sv
/*
 * phi2 slot arbiter
 *   slot counter restarted on every phi2 rising edge
 *   CPU read at slot 16, capture at slot 20, CPU write at slot 31
 *   host writes passed straight through, core reset output
 */
`timescale 1ns/10ps
`include "atom_params.svh"

module cycle_arbiter (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               cpu_phi2,
    input  logic               cpu_we,
    input  mem_pkg::cpu_addr_t cpu_addr,
    input  mem_pkg::byte_t     cpu_din,
    output mem_pkg::byte_t     cpu_dout,
    output logic               core_reset,
    dl_write_if.sink           dl,
    mem_req_if.master          mem
);

    localparam mem_pkg::slot_t SLOT_READ    = mem_pkg::slot_t'(`ATOM_SLOT_READ);
    localparam mem_pkg::slot_t SLOT_CAPTURE = mem_pkg::slot_t'(`ATOM_SLOT_CAPTURE);
    localparam mem_pkg::slot_t SLOT_WRITE   = mem_pkg::slot_t'(`ATOM_SLOT_WRITE);

    logic               phi2_q;
    logic               phi2_rise;
    mem_pkg::slot_t     slot;
    mem_pkg::slot_t     slot_next;
    mem_pkg::req_src_e  req_src;
    mem_pkg::byte_t     rd_hold;
    logic               cpu_rd_go;
    logic               cpu_wr_go;

    //////////////////////////////
    // Slot counter
    //////////////////////////////

    assign phi2_rise = cpu_phi2 & ~phi2_q;
    assign slot_next = phi2_rise ? '0 : slot + 1'b1;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            phi2_q <= 1'b0;
            slot   <= '0;
        end else begin
            phi2_q <= cpu_phi2;
            slot   <= slot_next;
        end
    end

    // Decided one cycle early so the pulse lines up with the slot itself
    assign cpu_rd_go = (slot_next == SLOT_READ) & ~dl.busy & ~cpu_we;
    assign cpu_wr_go = (slot_next == SLOT_WRITE) & ~dl.busy & cpu_we;

    //////////////////////////////
    // Request issue
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mem.rd  <= 1'b0;
            mem.we  <= 1'b0;
            req_src <= mem_pkg::req_none;
        end else begin
            mem.rd <= 1'b0;
            mem.we <= 1'b0;
            // Host writes only come while busy, so no overlap with CPU slots
            if (dl.valid) begin
                mem.we  <= 1'b1;
                req_src <= mem_pkg::req_host_write;
            end else if (cpu_rd_go) begin
                mem.rd  <= 1'b1;
                req_src <= mem_pkg::req_cpu_read;
            end else if (cpu_wr_go) begin
                mem.we  <= 1'b1;
                req_src <= mem_pkg::req_cpu_write;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dl.valid) begin
            mem.addr  <= dl.addr;
            mem.wdata <= dl.data;
        end else if (cpu_rd_go) begin
            mem.addr  <= cpu_addr;
        end else if (cpu_wr_go) begin
            mem.addr  <= cpu_addr;
            mem.wdata <= cpu_din;
        end
    end

    //////////////////////////////
    // Read return
    //////////////////////////////

    // Store answers at slot 18, held until the capture slot
    always_ff @(posedge clk_sys) begin
        if (mem.ready && req_src == mem_pkg::req_cpu_read) begin
            rd_hold <= mem.rdata;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_dout <= '0;
        end else if (slot == SLOT_CAPTURE) begin
            cpu_dout <= rd_hold;
        end
    end

    // Core held in reset through a download and its hold span
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= dl.busy;
        end
    end

endmodule

// File: src/download_loader.sv
/*
 * Host download loader
 *   keeps only ROM target writes (index bit 0 clear)
 *   idle / loading / holding FSM with the post-download reset hold
 */
`timescale 1ns/10ps
`include "atom_params.svh"

module download_loader (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  ioctl_download,
    input  host_pkg::file_index_t ioctl_index,
    input  logic                  ioctl_wr,
    input  host_pkg::host_addr_t  ioctl_addr,
    input  mem_pkg::byte_t        ioctl_dout,
    dl_write_if.source            dl
);

    localparam int HOLD_BITS = $clog2(`ATOM_HOLD_CYCLES);
    // Loaded when the download end is seen, the zero count costs one more cycle
    localparam logic [HOLD_BITS-1:0] HOLD_LAST = HOLD_BITS'(`ATOM_HOLD_CYCLES - 2);

    host_pkg::loader_state_e state;
    logic [HOLD_BITS-1:0]    hold_cnt;
    logic                    rom_wr;

    assign rom_wr = ioctl_download & ioctl_wr & ~ioctl_index[0];

    //////////////////////////////
    // Download FSM
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state    <= host_pkg::ld_idle;
            hold_cnt <= '0;
        end else begin
            case (state)
                host_pkg::ld_idle: begin
                    if (ioctl_download) begin
                        state <= host_pkg::ld_loading;
                    end
                end
                host_pkg::ld_loading: begin
                    if (!ioctl_download) begin
                        state    <= host_pkg::ld_holding;
                        hold_cnt <= HOLD_LAST;
                    end
                end
                host_pkg::ld_holding: begin
                    // A new download restarts the whole sequence
                    if (ioctl_download) begin
                        state <= host_pkg::ld_loading;
                    end else if (hold_cnt == '0) begin
                        state <= host_pkg::ld_idle;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= host_pkg::ld_idle;
                end
            endcase
        end
    end

    assign dl.busy = (state != host_pkg::ld_idle);

    //////////////////////////////
    // Write strobe and payload
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl.valid <= 1'b0;
        end else begin
            dl.valid <= rom_wr;
        end
    end

    // Host address is wider than the CPU bus, upper bits dropped
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            dl.addr <= ioctl_addr[`ATOM_CPU_ADDR_BITS-1:0];
            dl.data <= ioctl_dout;
        end
    end

endmodule

// File: src/mem_req_if.sv
/*
 * Interfaces inside the memory subsystem
 *   mem_req_if   arbiter to store, request/ready
 *   dl_write_if  loader to arbiter, filtered host writes
 */
`timescale 1ns/10ps

interface mem_req_if;

    mem_pkg::cpu_addr_t addr;
    mem_pkg::byte_t     wdata;
    logic               rd;
    logic               we;

    // Returned by the store, ready is a single pulse
    mem_pkg::byte_t     rdata;
    logic               ready;

    modport master (output addr, wdata, rd, we, input rdata, ready);
    modport slave  (input addr, wdata, rd, we, output rdata, ready);

endinterface

interface dl_write_if;

    // One-cycle write strobe, never stalled
    logic               valid;
    mem_pkg::cpu_addr_t addr;
    mem_pkg::byte_t     data;

    // Download in progress or hold span still running
    logic               busy;

    modport source (output valid, addr, data, busy);
    modport sink   (input valid, addr, data, busy);

endinterface

// File: src/host_pkg.sv
/*
 * Host download types
 *   host address and file index of the download stream
 *   loader FSM states
 */
`include "atom_params.svh"

package host_pkg;

    typedef logic [`ATOM_HOST_ADDR_BITS-1:0] host_addr_t;

    // Bit 0 clear selects the ROM target
    typedef logic [7:0] file_index_t;

    typedef enum logic [1:0] {
        ld_idle,
        ld_loading,
        ld_holding
    } loader_state_e;

endpackage

// File: src/mem_pkg.sv
/*
 * Memory side types
 *   CPU address, data byte, store address, slot count
 *   origin of the request in flight
 */
`include "atom_params.svh"

package mem_pkg;

    // 6502 side address as seen on the external bus
    typedef logic [`ATOM_CPU_ADDR_BITS-1:0] cpu_addr_t;

    typedef logic [7:0] byte_t;

    // Address bits decoded by the block RAM store
    typedef logic [`ATOM_STORE_ADDR_BITS-1:0] store_addr_t;

    // Position inside one phi2 period
    typedef logic [`ATOM_SLOT_BITS-1:0] slot_t;

    // Who issued the last request to the store
    typedef enum logic [1:0] {
        req_none,
        req_cpu_read,
        req_cpu_write,
        req_host_write
    } req_src_e;

endpackage

// File: src/atom_params.svh
/*
 * Build constants for the Atom memory subsystem
 *   bus and address widths, store depth
 *   phi2 slot numbers for read, capture and write
 *   reset hold length after a ROM download
 */
`ifndef ATOM_PARAMS_SVH
`define ATOM_PARAMS_SVH

// Bus widths
`define ATOM_CPU_ADDR_BITS    18
`define ATOM_HOST_ADDR_BITS   25

// 4 KB block RAM, higher address bits alias
`define ATOM_STORE_ADDR_BITS  12
`define ATOM_STORE_LATENCY    2

// Slots counted from the phi2 rising edge
`define ATOM_SLOT_BITS        5
`define ATOM_SLOT_READ        16
`define ATOM_SLOT_CAPTURE     20
`define ATOM_SLOT_WRITE       31

// Core stays in reset this long after a download
`define ATOM_HOLD_CYCLES      64

`endif
